//--- rv32_pkg.sv
// RV32I instruction encodings
package rv32_pkg;

    // register index and register value
    typedef logic [4:0] reg_addr_t;
    typedef logic [31:0] reg_value_t;

    // x0 through x31
    localparam int num_regs = 32;

    // major opcodes known to decode
    // anything else is illegal and halts the stage
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        SYSTEM = 7'b1110011
    } opcode_t;

    // ebreak lives in the priv group of SYSTEM
    localparam logic [11:0] funct12_ebreak = 12'h001;
    localparam logic [2:0] funct3_priv = 3'b000;

    // shift right, funct7 bit 5 selects arithmetic
    localparam logic [2:0] funct3_sr = 3'b101;

    // register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t rs2;
        reg_addr_t rs1;
        logic [2:0] funct3;
        reg_addr_t rd;
        opcode_t opcode;
    } r_fields_t;

    // register-immediate layout
    // imm12 overlays funct7 and rs2
    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t rs1;
        logic [2:0] funct3;
        reg_addr_t rd;
        opcode_t opcode;
    } i_fields_t;

    // one instruction word, read either way
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_word_u;

endpackage

//--- decode_pkg.sv
// Decode stage types
package decode_pkg;

    // sweep clears the register file after reset
    // exit swallows everything until the next reset
    typedef enum logic [1:0] {
        SWEEP  = 2'b00,
        NORMAL = 2'b01,
        EXIT   = 2'b10
    } decode_state_t;

    // tag that keeps decode in step with jumps
    typedef logic [1:0] jump_flag_t;

    // per register issue and writeback counters
    typedef logic [2:0] reg_status_t;

    // what the execute stage is asked to do
    typedef enum logic [1:0] {
        ALU_REG = 2'b00,
        ALU_IMM = 2'b01,
        HALT    = 2'b10
    } exec_kind_t;

    // command handed to execute
    typedef struct packed {
        exec_kind_t kind;
        logic [2:0] funct3;
        // funct7 bit 5, sub and sra
        logic alt;
        rv32_pkg::reg_addr_t rd;
        // front counter of rd before this issue
        reg_status_t rd_status;
        rv32_pkg::reg_value_t operand_a;
        rv32_pkg::reg_value_t operand_b;
        logic [31:0] pc;
        jump_flag_t jump_flag;
    } exec_command_t;

    // count of issued commands
    typedef logic [31:0] retired_count_t;

    // exit code for an unsupported opcode
    localparam logic [7:0] exit_code_illegal = 8'd1;

endpackage

//--- regfile_if.sv
// Register file port bundle
`timescale 1ns/1ps

interface regfile_if;

    // single write port
    logic write_enable;
    rv32_pkg::reg_addr_t write_addr;
    rv32_pkg::reg_value_t write_value;

    // two combinational read ports
    rv32_pkg::reg_addr_t rs1_addr;
    rv32_pkg::reg_addr_t rs2_addr;
    rv32_pkg::reg_value_t rs1_value;
    rv32_pkg::reg_value_t rs2_value;

    modport storage (
        input  write_enable, write_addr, write_value,
        input  rs1_addr, rs2_addr,
        output rs1_value, rs2_value
    );

    modport reader (output rs1_addr, rs2_addr, input rs1_value, rs2_value);

    modport writer (output write_enable, write_addr, write_value);

endinterface

//--- decode_control.sv
// Decode state machine
`timescale 1ns/1ps

module decode_control (
    input  logic clk,
    input  logic arst_n,
    input  logic sweep_done,
    input  logic instr_valid,
    input  logic instr_stale,
    input  logic operands_ready,
    input  logic slot_free,
    input  logic is_illegal,
    input  logic is_ebreak,
    output decode_pkg::decode_state_t state,
    output logic instr_ready,
    output logic issue,
    output logic halt
);

    decode_pkg::decode_state_t next_state;
    logic accept;
    logic in_normal;

    assign in_normal = (state == decode_pkg::NORMAL);

    // stale words go without operands, but still need the slot
    // exit drains whatever arrives
    assign instr_ready = (in_normal && slot_free && (instr_stale || operands_ready))
            || (state == decode_pkg::EXIT);

    assign accept = instr_valid && instr_ready;

    // only live instructions in normal produce a command
    assign issue = accept && in_normal && !instr_stale;

    // halt command replaces ebreak and illegal opcodes
    assign halt = issue && (is_illegal || is_ebreak);

    always_comb begin
        next_state = state;
        unique case (state)
            decode_pkg::SWEEP: begin
                // last register cleared this cycle
                if (sweep_done) begin
                    next_state = decode_pkg::NORMAL;
                end
            end
            decode_pkg::NORMAL: begin
                if (halt) begin
                    next_state = decode_pkg::EXIT;
                end
            end
            decode_pkg::EXIT: begin
                // held until reset
                next_state = decode_pkg::EXIT;
            end
            default: begin
                next_state = decode_pkg::SWEEP;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= decode_pkg::SWEEP;
        end else begin
            state <= next_state;
        end
    end

endmodule

//--- decode_counters.sv
// Sweep, jump and retire counters
`timescale 1ns/1ps

module decode_counters (
    input  logic clk,
    input  logic arst_n,
    input  decode_pkg::decode_state_t state,
    input  logic jump_valid,
    input  logic issue,
    output rv32_pkg::reg_addr_t sweep_addr,
    output logic sweep_done,
    output decode_pkg::jump_flag_t jump_flag,
    output decode_pkg::retired_count_t retired_instructions
);

    logic sweeping;

    assign sweeping = (state == decode_pkg::SWEEP);

    // one register per cycle
    // x31 is the last one cleared
    assign sweep_done = (sweep_addr == rv32_pkg::reg_addr_t'(rv32_pkg::num_regs - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sweep_addr <= '0;
            jump_flag <= '0;
            retired_instructions <= '0;
        end else begin
            if (sweeping) begin
                sweep_addr <= sweep_addr + 1'b1;
            end
            // wrapping flag
            // only equality with the tag matters
            if (jump_valid) begin
                jump_flag <= jump_flag + 1'b1;
            end
            // halt command counts too
            if (issue) begin
                retired_instructions <= retired_instructions + 1'b1;
            end
        end
    end

endmodule

//--- register_file.sv
// Integer register file
`timescale 1ns/1ps

module register_file (
    input  logic clk,
    input  logic arst_n,
    regfile_if.storage regs
);

    rv32_pkg::reg_value_t mem [rv32_pkg::num_regs];
    logic write_ok;
    rv32_pkg::reg_value_t write_data;

    // no writes while held in reset
    assign write_ok = regs.write_enable && arst_n;

    // x0 only ever takes zero
    // the sweep's zero write is what sets it
    assign write_data = (regs.write_addr == '0) ? '0 : regs.write_value;

    always_ff @(posedge clk) begin
        if (write_ok) begin
            mem[regs.write_addr] <= write_data;
        end
    end

    // reads see a write one edge later
    // a stalled reader then goes on the next edge
    assign regs.rs1_value = mem[regs.rs1_addr];
    assign regs.rs2_value = mem[regs.rs2_addr];

endmodule

//--- register_scoreboard.sv
// Register status scoreboard
`timescale 1ns/1ps

module register_scoreboard (
    input  logic clk,
    input  logic arst_n,
    input  decode_pkg::decode_state_t state,
    input  rv32_pkg::reg_addr_t sweep_addr,
    input  rv32_pkg::reg_addr_t issue_rd,
    input  logic issue_write,
    input  logic wb_valid,
    input  rv32_pkg::reg_addr_t wb_addr,
    input  rv32_pkg::reg_addr_t rs1_addr,
    input  rv32_pkg::reg_addr_t rs2_addr,
    output decode_pkg::reg_status_t rd_status,
    output logic operands_ready
);

    // front steps on issue, rear on writeback
    decode_pkg::reg_status_t front [rv32_pkg::num_regs];
    decode_pkg::reg_status_t rear [rv32_pkg::num_regs];
    logic sweeping;
    logic wb_step;
    logic rs1_pending;
    logic rs2_pending;

    assign sweeping = (state == decode_pkg::SWEEP);

    // x0 is never issued, so its writebacks are ignored
    assign wb_step = wb_valid && !sweeping && (wb_addr != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            front <= '{default: '0};
            rear <= '{default: '0};
        end else if (sweeping) begin
            front[sweep_addr] <= '0;
            rear[sweep_addr] <= '0;
        end else begin
            if (issue_write) begin
                front[issue_rd] <= front[issue_rd] + 1'b1;
            end
            if (wb_step) begin
                rear[wb_addr] <= rear[wb_addr] + 1'b1;
            end
        end
    end

    // counters differ while a result is outstanding
    assign rs1_pending = (front[rs1_addr] != rear[rs1_addr]);
    assign rs2_pending = (front[rs2_addr] != rear[rs2_addr]);
    assign operands_ready = !rs1_pending && !rs2_pending;

    // tag carried by the command for the writer
    assign rd_status = front[issue_rd];

endmodule

//--- command_builder.sv
// Execute command builder
`timescale 1ns/1ps

module command_builder (
    input  logic clk,
    input  logic arst_n,
    input  logic [31:0] instr_data,
    input  logic [31:0] instr_pc,
    input  decode_pkg::jump_flag_t jump_flag,
    input  decode_pkg::reg_status_t rd_status,
    input  logic issue,
    input  logic exec_ready,
    output logic exec_valid,
    output decode_pkg::exec_command_t exec_command,
    output logic slot_free,
    output logic is_illegal,
    output logic is_ebreak,
    output logic [7:0] exit_code,
    output logic exit_flag,
    output rv32_pkg::reg_addr_t issue_rd,
    output rv32_pkg::reg_addr_t rs1_addr,
    output rv32_pkg::reg_addr_t rs2_addr,
    regfile_if.reader regs
);

    rv32_pkg::instr_word_u word;
    logic is_op;
    logic is_op_imm;
    logic is_shift_imm;
    logic halt_issue;
    rv32_pkg::reg_value_t imm_ext;
    decode_pkg::exec_command_t next_command;

    assign word = instr_data;

    // opcode decode
    assign is_op = (word.r.opcode == rv32_pkg::OP);
    assign is_op_imm = (word.i.opcode == rv32_pkg::OP_IMM);
    assign is_shift_imm = is_op_imm && (word.i.funct3 == rv32_pkg::funct3_sr);
    assign is_ebreak = (word.i.opcode == rv32_pkg::SYSTEM)
            && (word.i.funct3 == rv32_pkg::funct3_priv)
            && (word.i.imm12 == rv32_pkg::funct12_ebreak);
    assign is_illegal = !(is_op || is_op_imm || is_ebreak);

    // rs2 bits are immediate outside OP, read x0 there
    assign rs1_addr = word.r.rs1;
    assign rs2_addr = is_op ? word.r.rs2 : '0;
    assign regs.rs1_addr = rs1_addr;
    assign regs.rs2_addr = rs2_addr;
    assign issue_rd = word.r.rd;

    assign imm_ext = {{20{word.i.imm12[11]}}, word.i.imm12};

    always_comb begin
        if (is_illegal || is_ebreak) begin
            next_command.kind = decode_pkg::HALT;
        end else if (is_op) begin
            next_command.kind = decode_pkg::ALU_REG;
        end else begin
            next_command.kind = decode_pkg::ALU_IMM;
        end
        next_command.funct3 = word.r.funct3;
        // srai reuses funct7 bit 5 inside the immediate
        next_command.alt = (is_op || is_shift_imm) && word.r.funct7[5];
        next_command.rd = (is_op || is_op_imm) ? word.r.rd : '0;
        next_command.rd_status = rd_status;
        next_command.operand_a = regs.rs1_value;
        next_command.operand_b = is_op ? regs.rs2_value : imm_ext;
        next_command.pc = instr_pc;
        next_command.jump_flag = jump_flag;
    end

    assign halt_issue = issue && (is_illegal || is_ebreak);

    // single slot, refills on the edge it drains
    assign slot_free = !exec_valid || exec_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exec_valid <= 1'b0;
        end else if (issue) begin
            exec_valid <= 1'b1;
        end else if (exec_ready) begin
            exec_valid <= 1'b0;
        end
    end

    // only loaded when the slot is free
    always_ff @(posedge clk) begin
        if (issue) begin
            exec_command <= next_command;
        end
    end

    // exit status, sticky until reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exit_flag <= 1'b0;
            exit_code <= '0;
        end else if (halt_issue) begin
            exit_flag <= 1'b1;
            exit_code <= is_ebreak ? regs.rs1_value[7:0] : decode_pkg::exit_code_illegal;
        end
    end

endmodule

//--- gecko_decode_top.sv
// RV32I decode stage
`timescale 1ns/1ps

module gecko_decode_top (
    input  logic clk,
    input  logic arst_n,
    // instruction stream
    input  logic instr_valid,
    output logic instr_ready,
    input  logic [31:0] instr_data,
    input  logic [31:0] instr_pc,
    input  decode_pkg::jump_flag_t instr_jump_flag,
    // execute stream
    output logic exec_valid,
    input  logic exec_ready,
    output decode_pkg::exec_command_t exec_command,
    // writeback, never stalled
    input  logic wb_valid,
    input  rv32_pkg::reg_addr_t wb_addr,
    input  rv32_pkg::reg_value_t wb_value,
    input  logic jump_valid,
    // status
    output logic exit_flag,
    output logic [7:0] exit_code,
    output decode_pkg::retired_count_t retired_instructions
);

    decode_pkg::decode_state_t state;
    rv32_pkg::reg_addr_t sweep_addr;
    logic sweep_done;
    decode_pkg::jump_flag_t jump_flag;
    logic instr_stale;
    logic operands_ready;
    logic slot_free;
    logic is_illegal;
    logic is_ebreak;
    logic issue;
    logic halt;
    logic issue_write;
    decode_pkg::reg_status_t rd_status;
    rv32_pkg::reg_addr_t issue_rd;
    rv32_pkg::reg_addr_t rs1_addr;
    rv32_pkg::reg_addr_t rs2_addr;

    regfile_if regs ();

    // tag from before any jump this cycle
    assign instr_stale = (instr_jump_flag != jump_flag);

    // halts and x0 leave the scoreboard alone
    assign issue_write = issue && !halt && (issue_rd != '0);

    // sweep owns the write port, writebacks after
    always_comb begin
        if (state == decode_pkg::SWEEP) begin
            regs.write_enable = 1'b1;
            regs.write_addr = sweep_addr;
            regs.write_value = '0;
        end else begin
            regs.write_enable = wb_valid;
            regs.write_addr = wb_addr;
            regs.write_value = wb_value;
        end
    end

    decode_control u_control (
        .clk, .arst_n, .sweep_done, .instr_valid, .instr_stale, .operands_ready,
        .slot_free, .is_illegal, .is_ebreak, .state, .instr_ready, .issue, .halt
    );

    decode_counters u_counters (
        .clk, .arst_n, .state, .jump_valid, .issue,
        .sweep_addr, .sweep_done, .jump_flag, .retired_instructions
    );

    register_file u_register_file (.clk, .arst_n, .regs(regs.storage));

    register_scoreboard u_scoreboard (
        .clk, .arst_n, .state, .sweep_addr, .issue_rd, .issue_write,
        .wb_valid, .wb_addr, .rs1_addr, .rs2_addr, .rd_status, .operands_ready
    );

    command_builder u_builder (
        .clk, .arst_n, .instr_data, .instr_pc, .jump_flag, .rd_status, .issue,
        .exec_ready, .exec_valid, .exec_command, .slot_free, .is_illegal,
        .is_ebreak, .exit_code, .exit_flag, .issue_rd, .rs1_addr, .rs2_addr,
        .regs(regs.reader)
    );

endmodule

//--- decode_assertions.sv
// Decode protocol assertions
`timescale 1ns/1ps

module decode_assertions (
    input  logic clk,
    input  logic arst_n,
    input  logic instr_ready,
    input  logic exec_valid,
    input  logic exec_ready,
    input  decode_pkg::exec_command_t exec_command,
    input  logic exit_flag
);

    // number of assertion failures so far
    int failures = 0;
    // edges seen since reset
    // saturates at the sweep length
    logic [5:0] since_reset;
    // halt command already taken by execute
    logic halt_done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            since_reset <= '0;
            halt_done <= 1'b0;
        end else begin
            if (since_reset < 6'd32) begin
                since_reset <= since_reset + 1'b1;
            end
            if (exec_valid && exec_ready && exec_command.kind == decode_pkg::HALT) begin
                halt_done <= 1'b1;
            end
        end
    end

    // stalled command must not move
    held_command: assert property (@(posedge clk) disable iff (!arst_n)
            exec_valid && !exec_ready |=> $stable(exec_command))
        else begin
            failures++;
            $error("exec_command changed while exec_ready was low");
        end

    // nothing in or out while the sweep runs
    quiet_sweep: assert property (@(posedge clk) disable iff (!arst_n)
            since_reset < 6'd32 |-> !instr_ready && !exec_valid)
        else begin
            failures++;
            $error("handshake active during the reset sweep");
        end

    // sticky until reset
    exit_sticky: assert property (@(posedge clk) disable iff (!arst_n)
            !$fell(exit_flag))
        else begin
            failures++;
            $error("exit_flag dropped without reset");
        end

    quiet_after_halt: assert property (@(posedge clk) disable iff (!arst_n)
            halt_done |-> !exec_valid)
        else begin
            failures++;
            $error("command issued after the halt command");
        end

endmodule

//--- tb_decode.sv
// Decode stage testbench
`timescale 1ns/1ps

module tb_decode;

    localparam logic [31:0] seed = 32'h08cf_5c8f;
    localparam int random_count = 60;
    // two reset sweeps, then a generous bound per instruction sent
    localparam int cycle_limit = 2 * (2 + 32) + 20 * (random_count + 40);

    logic clk = 1'b0;
    logic arst_n;
    logic instr_valid;
    logic instr_ready;
    logic [31:0] instr_data;
    logic [31:0] instr_pc;
    decode_pkg::jump_flag_t instr_jump_flag;
    logic exec_valid;
    logic exec_ready;
    decode_pkg::exec_command_t exec_command;
    logic wb_valid;
    rv32_pkg::reg_addr_t wb_addr;
    rv32_pkg::reg_value_t wb_value;
    logic jump_valid;
    logic exit_flag;
    logic [7:0] exit_code;
    decode_pkg::retired_count_t retired_instructions;

    // reference model of the stage
    rv32_pkg::reg_value_t model_regs [32];
    decode_pkg::reg_status_t model_front [32];
    decode_pkg::jump_flag_t model_flag;
    logic model_exited;
    int model_retired;
    // issued writers waiting for a writeback, oldest first
    rv32_pkg::reg_addr_t outstanding [$];
    decode_pkg::exec_command_t expected [$];

    logic [31:0] rnd = seed;
    logic [31:0] gap_rnd = seed;
    logic random_gaps = 1'b0;
    string test_name = "reset";
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int errors_at_start;
    // stall cycles of the last instruction sent
    int waited;

    gecko_decode_top DUT (.*);

    bind gecko_decode_top decode_assertions u_assertions (
        .clk(clk), .arst_n(arst_n), .instr_ready(instr_ready), .exec_valid(exec_valid),
        .exec_ready(exec_ready), .exec_command(exec_command), .exit_flag(exit_flag)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] random_word();
        rnd = xorshift(rnd);
        return rnd;
    endfunction

    function automatic logic [31:0] i_type(input logic [4:0] rd, input logic [4:0] rs1,
            input logic [2:0] funct3, input logic [11:0] imm);
        return {imm, rs1, funct3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic int total_errors();
        return errors + DUT.u_assertions.failures;
    endfunction

    task automatic compare(input string what, input logic [127:0] want,
            input logic [127:0] got);
        if (got !== want) begin
            $display("ERR %s %s: expected %0h, actual %0h", test_name, what, want, got);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = total_errors();
    endtask

    task automatic end_test;
        tests_run++;
        if (total_errors() != errors_at_start) begin
            tests_failed++;
            $display("%s: FAIL", test_name);
        end else begin
            $display("%s: ok", test_name);
        end
    endtask

    // called at a falling edge, like every driving task
    task automatic apply_reset;
        arst_n = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
            model_front[i] = '0;
        end
        model_flag = '0;
        model_exited = 1'b0;
        model_retired = 0;
        outstanding.delete();
        expected.delete();
    endtask

    // command the accepted word must produce
    task automatic expect_command(input logic [31:0] data);
        decode_pkg::exec_command_t cmd;
        logic is_op;
        logic is_imm;
        logic halt;
        is_op = (data[6:0] == 7'b0110011);
        is_imm = (data[6:0] == 7'b0010011);
        halt = !is_op && !is_imm;
        cmd.kind = halt ? decode_pkg::HALT : (is_op ? decode_pkg::ALU_REG : decode_pkg::ALU_IMM);
        cmd.funct3 = data[14:12];
        // bit 30 only for OP and srai
        cmd.alt = (is_op || (is_imm && data[14:12] == 3'b101)) && data[30];
        cmd.rd = halt ? 5'd0 : data[11:7];
        cmd.rd_status = model_front[data[11:7]];
        cmd.operand_a = model_regs[data[19:15]];
        cmd.operand_b = is_op ? model_regs[data[24:20]] : {{20{data[31]}}, data[31:20]};
        cmd.pc = instr_pc;
        cmd.jump_flag = model_flag;
        expected.push_back(cmd);
        model_retired++;
        model_exited = halt;
        if (!halt && data[11:7] != 5'd0) begin
            model_front[data[11:7]] = model_front[data[11:7]] + 1'b1;
            outstanding.push_back(data[11:7]);
        end
    endtask

    // returns at the falling edge after the transfer
    task automatic send_instr(input logic [31:0] data, input decode_pkg::jump_flag_t flag);
        instr_valid = 1'b1;
        instr_data = data;
        instr_jump_flag = flag;
        waited = 0;
        #5;
        while (!instr_ready) begin
            @(negedge clk);
            #5;
            waited++;
        end
        // transfer on the coming rising edge
        if (flag == model_flag && !model_exited) begin
            expect_command(data);
        end
        @(negedge clk);
        instr_valid = 1'b0;
        instr_pc = instr_pc + 32'd4;
    endtask

    task automatic writeback(input rv32_pkg::reg_addr_t addr, input rv32_pkg::reg_value_t value);
        wb_valid = 1'b1;
        wb_addr = addr;
        wb_value = value;
        model_regs[addr] = value;
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    task automatic retire_all;
        while (outstanding.size() != 0) begin
            writeback(outstanding.pop_front(), random_word());
        end
    endtask

    // addi to claim rd, then its writeback carries the value
    task automatic load_reg(input rv32_pkg::reg_addr_t rd, input rv32_pkg::reg_value_t value);
        send_instr(i_type(rd, 5'd0, 3'b000, 12'h000), model_flag);
        void'(outstanding.pop_back());
        writeback(rd, value);
    endtask

    task automatic drain;
        while (expected.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    // execute side, ready gaps and command checks
    always begin : exec_monitor
        decode_pkg::exec_command_t want;
        @(negedge clk);
        if (random_gaps) begin
            gap_rnd = xorshift(gap_rnd);
            exec_ready = (gap_rnd[1:0] != 2'b00);
        end else begin
            exec_ready = 1'b1;
        end
        #5;
        if (exec_valid && exec_ready) begin
            if (expected.size() == 0) begin
                $display("%s: unexpected command at pc %0h", test_name, exec_command.pc);
                errors++;
            end else begin
                want = expected.pop_front();
                compare("command", want, exec_command);
            end
        end
    end

    initial begin : watchdog
        int count;
        count = 0;
        while (count < cycle_limit) begin
            @(posedge clk);
            count++;
        end
        $display("timeout, run exceeded %0d cycles", cycle_limit);
        $display("Test failures found");
        $finish;
    end

    initial begin : main
        logic [31:0] word;
        arst_n = 1'b0;
        instr_valid = 1'b0;
        instr_data = '0;
        instr_pc = 32'h0000_1000;
        instr_jump_flag = '0;
        exec_ready = 1'b1;
        wb_valid = 1'b0;
        wb_addr = '0;
        wb_value = '0;
        jump_valid = 1'b0;
        apply_reset;

        start_test("sweep");
        compare("retired after reset", 0, retired_instructions);
        compare("exit code after reset", 0, exit_code);
        send_instr(i_type(5'd0, 5'd0, 3'b000, 12'h000), model_flag);
        compare("sweep cycles", 32, waited);
        drain;
        end_test;

        start_test("operands");
        load_reg(5'd5, random_word());
        load_reg(5'd6, random_word());
        word = random_word();
        send_instr(i_type(5'd7, 5'd5, 3'b000, {1'b1, word[10:0]}), model_flag);
        send_instr(i_type(5'd8, 5'd6, 3'b111, {1'b0, word[22:12]}), model_flag);
        send_instr(r_type(7'h00, 5'd6, 5'd5, 3'b000, 5'd9), model_flag);
        send_instr(r_type(7'h20, 5'd6, 5'd5, 3'b000, 5'd10), model_flag);
        send_instr(i_type(5'd11, 5'd6, 3'b101, 12'h403), model_flag);
        retire_all;
        drain;
        end_test;

        start_test("stall");
        send_instr(i_type(5'd12, 5'd0, 3'b000, 12'h123), model_flag);
        fork
            send_instr(r_type(7'h00, 5'd5, 5'd12, 3'b000, 5'd13), model_flag);
            begin
                repeat (4) @(negedge clk);
                writeback(outstanding.pop_front(), random_word());
            end
        join
        // writeback at edge N, reader goes at N+1
        compare("stall cycles", 5, waited);
        retire_all;
        drain;
        end_test;

        start_test("random");
        random_gaps = 1'b1;
        for (int n = 0; n < random_count; n++) begin
            word = random_word();
            word[11:7] = word[6] ? word[11:7] : 5'd0;
            word[6:0] = word[5] ? 7'b0110011 : 7'b0010011;
            send_instr(word, model_flag);
            retire_all;
        end
        drain;
        random_gaps = 1'b0;
        compare("retired count", model_retired, retired_instructions);
        end_test;

        start_test("jump");
        jump_valid = 1'b1;
        @(negedge clk);
        jump_valid = 1'b0;
        model_flag = model_flag + 1'b1;
        send_instr(i_type(5'd14, 5'd5, 3'b000, 12'h001), model_flag - 1'b1);
        send_instr(r_type(7'h00, 5'd6, 5'd5, 3'b000, 5'd15), model_flag - 1'b1);
        drain;
        compare("retired after stale", model_retired, retired_instructions);
        send_instr(i_type(5'd14, 5'd5, 3'b000, 12'h001), model_flag);
        retire_all;
        drain;
        compare("retired after jump", model_retired, retired_instructions);
        end_test;

        start_test("exit");
        load_reg(5'd16, random_word());
        send_instr({12'h001, 5'd16, 3'b000, 5'd0, 7'b1110011}, model_flag);
        // swallowed once halted
        send_instr(i_type(5'd17, 5'd0, 3'b000, 12'h00f), model_flag);
        drain;
        compare("exit flag", 1, exit_flag);
        compare("ebreak exit code", model_regs[16][7:0], exit_code);
        compare("retired at exit", model_retired, retired_instructions);
        apply_reset;
        send_instr({12'h0ab, 5'd0, 3'b000, 5'd0, 7'b1111111}, model_flag);
        drain;
        compare("illegal exit flag", 1, exit_flag);
        compare("illegal exit code", 1, exit_code);
        compare("retired after illegal", 1, retired_instructions);
        end_test;

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- list.f
rv32_pkg.sv
decode_pkg.sv
regfile_if.sv
decode_control.sv
decode_counters.sv
register_file.sv
register_scoreboard.sv
command_builder.sv
gecko_decode_top.sv
decode_assertions.sv
tb_decode.sv
